// ==== verilog/tb_params.svh ====
`ifndef TB_PARAMS_SVH
`define TB_PARAMS_SVH

// Lanes per row and bits per lane.
`define TB_LANES 4
`define TB_DW 32

// Bank depth is 2**TB_AW rows.
`define TB_AW 6

// Sequence count width, wider than a burst needs.
`define TB_SEQ_DW 5

// Burst shape.
`define TB_BURST_LEN 8
`define TB_RD_LAT 3
`define TB_DRAIN 4

`endif

// ==== verilog/tb_map_pkg.sv ====
`include "tb_params.svh"

package tb_map_pkg;

  // B operand modes.
  typedef enum logic [1:0] {
    DIR_IDLE = 2'd0,
    DIR_POS  = 2'd1,
    DIR_NEG  = 2'd2,
    DIR_NEW  = 2'd3
  } dir_mode_e;

  // B cache modes.
  typedef enum logic [1:0] {
    CACHE_IDLE      = 2'd0,
    CACHE_TRANSFER  = 2'd1,
    CACHE_TRANSPOSE = 2'd2,
    CACHE_INV       = 2'd3
  } cache_mode_e;

  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_ADDR  = 2'd1,
    ST_DRAIN = 2'd2
  } seq_state_e;

  localparam logic TGT_B     = 1'b0;
  localparam logic TGT_CACHE = 1'b1;

  // Mode reads as dir_mode_e or cache_mode_e by target.
  typedef struct packed {
    logic       target;
    logic [1:0] mode;
  } tb_sel_t;

  localparam tb_sel_t SEL_IDLE = '{target: TGT_B, mode: DIR_IDLE};

  // Lane 0 sits in the low bits.
  typedef logic [`TB_LANES-1:0][`TB_DW-1:0] tb_row_t;

  typedef struct packed {
    tb_sel_t           sel;
    logic              l_k_0;
    logic [`TB_AW-1:0] base;
  } tb_cmd_t;

endpackage

// ==== verilog/dynamic_shreg.sv ====
`timescale 1ns/10ps

module dynamic_shreg #(
  parameter int DW = 8,
  parameter int AW = 2
) (
  input  logic          clk,
  input  logic          ce,
  input  logic [AW-1:0] addr,
  input  logic [DW-1:0] din,
  output logic [DW-1:0] dout
);

  localparam int DEPTH = 2 ** AW;

  logic [DW-1:0] taps [DEPTH];

  // Tap n holds din from n+1 enabled edges ago.
  always_ff @(posedge clk) begin
    if (ce) begin
      taps[0] <= din;
      for (int i = 1; i < DEPTH; i++) begin
        taps[i] <= taps[i-1];
      end
    end
  end

  assign dout = taps[addr];

endmodule

// ==== verilog/tb_bank.sv ====
`timescale 1ns/10ps
`include "tb_params.svh"

module tb_bank
  import tb_map_pkg::*;
(
  input  logic              clk,
  input  logic              sys_rst,
  input  logic              wr_en,
  input  logic [`TB_AW-1:0] wr_addr,
  input  tb_row_t           wr_row,
  input  logic [`TB_AW-1:0] rd_addr,
  output tb_row_t           rd_row
);

  localparam int DEPTH = 2 ** `TB_AW;

  tb_row_t           mem [DEPTH];
  logic [`TB_AW-1:0] addr_q;
  tb_row_t           data_q;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_row;
    end
  end

  // Address, array and output stages.
  always_ff @(posedge clk) begin
    addr_q <= rd_addr;
    data_q <= mem[addr_q];
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      rd_row <= '0;
    end else begin
      rd_row <= data_q;
    end
  end

  a_wr_addr_known: assert property (
    @(posedge clk) disable iff (sys_rst)
    wr_en |-> !$isunknown(wr_addr)
  ) else $error("tb_bank write with unknown address");

endmodule

// ==== verilog/tb_read_seq.sv ====
`timescale 1ns/10ps
`include "tb_params.svh"

module tb_read_seq
  import tb_map_pkg::*;
(
  input  logic                  clk,
  input  logic                  sys_rst,
  input  logic                  cmd_start,
  input  tb_cmd_t               cmd,
  output logic                  busy,
  output logic [`TB_AW-1:0]     rd_addr,
  output logic [`TB_SEQ_DW-1:0] seq_cnt,
  output tb_sel_t               sel,
  output logic                  l_k_0
);

  localparam int TOTAL = `TB_BURST_LEN + `TB_DRAIN;
  localparam int CNT_W = $clog2(TOTAL);
  localparam logic [CNT_W-1:0] LAST_ADDR = CNT_W'(`TB_BURST_LEN - 1);
  localparam logic [CNT_W-1:0] LAST_CYC  = CNT_W'(TOTAL - 1);
  localparam logic [`TB_SEQ_DW-1:0] LAST_SEQ = `TB_SEQ_DW'(`TB_BURST_LEN - 1);

  seq_state_e       state_q;
  logic [CNT_W-1:0] cnt_q;

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
      busy    <= 1'b0;
      sel     <= SEL_IDLE;
      l_k_0   <= 1'b0;
      rd_addr <= '0;
      seq_cnt <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          // Start pulses only count here.
          if (cmd_start) begin
            state_q <= ST_ADDR;
            cnt_q   <= '0;
            busy    <= 1'b1;
            sel     <= cmd.sel;
            l_k_0   <= cmd.l_k_0;
            rd_addr <= cmd.base;
            seq_cnt <= '0;
          end
        end
        ST_ADDR: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == LAST_ADDR) begin
            state_q <= ST_DRAIN;
            seq_cnt <= '0;
          end else begin
            rd_addr <= rd_addr + 1'b1;
            seq_cnt <= seq_cnt + 1'b1;
          end
        end
        ST_DRAIN: begin
          // Select stays until the last rows leave the map.
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == LAST_CYC) begin
            state_q <= ST_IDLE;
            busy    <= 1'b0;
            sel     <= SEL_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  a_busy_len: assert property (
    @(posedge clk) disable iff (sys_rst)
    $rose(busy) |-> busy [*TOTAL] ##1 !busy
  ) else $error("tb_read_seq busy length wrong");

  a_seq_range: assert property (
    @(posedge clk) disable iff (sys_rst)
    seq_cnt <= LAST_SEQ
  ) else $error("tb_read_seq sequence count out of range");

endmodule

// ==== verilog/tb_doutb_map.sv ====
`timescale 1ns/10ps
`include "tb_params.svh"

module tb_doutb_map
  import tb_map_pkg::*;
(
  input  logic                  clk,
  input  logic                  sys_rst,
  input  tb_sel_t               sel,
  input  logic                  l_k_0,
  input  logic [`TB_SEQ_DW-1:0] seq_cnt,
  input  tb_row_t               doutb,
  output tb_row_t               b_row,
  output tb_row_t               b_cache_row
);

  logic [`TB_SEQ_DW-1:0] d_cnt;
  logic [`TB_DW-1:0]     p0;
  logic [`TB_DW-1:0]     p1;
  logic                  inv_mode;
  logic [`TB_DW-1:0]     s11_q;
  logic [`TB_DW-1:0]     s12_q;
  logic [`TB_DW-1:0]     s22_q;
  logic [`TB_DW-1:0]     s11_s22_q;
  logic [`TB_DW-1:0]     s12_s21_q;
  logic [`TB_DW-1:0]     det_q;
  logic [`TB_DW-1:0]     inv_num;
  logic [`TB_DW-1:0]     inv_quo;
  tb_row_t               b_next;
  tb_row_t               cache_next;

  // Sequence count aligned with the bank output row.
  dynamic_shreg #(
    .DW (`TB_SEQ_DW),
    .AW (2)
  ) u_seq_dly (
    .clk  (clk),
    .ce   (1'b1),
    .addr (2'(`TB_RD_LAT - 1)),
    .din  (seq_cnt),
    .dout (d_cnt)
  );

  // Half-row pair, lower when l_k_0 is set.
  assign p0 = l_k_0 ? doutb[0] : doutb[2];
  assign p1 = l_k_0 ? doutb[1] : doutb[3];

  assign inv_mode = (sel.target == TGT_CACHE) && (cache_mode_e'(sel.mode) == CACHE_INV);

  // One shared divider for the three inverse terms.
  assign inv_num = (d_cnt == `TB_SEQ_DW'(5)) ? s11_q :
                   (d_cnt == `TB_SEQ_DW'(6)) ? s12_q : s22_q;
  assign inv_quo = inv_num / det_q;

  always_comb begin
    b_next = '0;
    if (sel.target == TGT_B) begin
      case (dir_mode_e'(sel.mode))
        DIR_POS: b_next = doutb;
        DIR_NEG: begin
          for (int i = 0; i < `TB_LANES; i++) begin
            b_next[i] = doutb[`TB_LANES-1-i];
          end
        end
        DIR_NEW: begin
          b_next[0] = p0;
          b_next[1] = p1;
        end
        default: b_next = '0;
      endcase
    end
  end

  always_comb begin
    cache_next = '0;
    if (sel.target == TGT_CACHE) begin
      case (cache_mode_e'(sel.mode))
        CACHE_TRANSFER: begin
          cache_next[0] = doutb[0];
          cache_next[1] = doutb[1];
        end
        CACHE_TRANSPOSE: begin
          // Staggered so each column enters one cycle after the last.
          case (d_cnt)
            `TB_SEQ_DW'(1): cache_next[0] = doutb[0];
            `TB_SEQ_DW'(2): begin
              cache_next[0] = doutb[1];
              cache_next[1] = doutb[0];
            end
            `TB_SEQ_DW'(3): begin
              cache_next[0] = doutb[2];
              cache_next[1] = doutb[1];
            end
            `TB_SEQ_DW'(4): cache_next[1] = doutb[2];
            `TB_SEQ_DW'(5): cache_next[0] = p0;
            `TB_SEQ_DW'(6): begin
              cache_next[0] = p1;
              cache_next[1] = p0;
            end
            `TB_SEQ_DW'(7): cache_next[1] = p1;
            default: cache_next = '0;
          endcase
        end
        CACHE_INV: begin
          case (d_cnt)
            `TB_SEQ_DW'(5): cache_next[0] = inv_quo;
            `TB_SEQ_DW'(6): begin
              cache_next[0] = inv_quo;
              cache_next[1] = inv_quo;
            end
            `TB_SEQ_DW'(7): cache_next[1] = inv_quo;
            default: cache_next = '0;
          endcase
        end
        default: cache_next = '0;
      endcase
    end
  end

  // 2x2 inverse terms, collected over counts 1 to 4.
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      s11_q     <= '0;
      s12_q     <= '0;
      s22_q     <= '0;
      s11_s22_q <= '0;
      s12_s21_q <= '0;
      det_q     <= '0;
    end else if (inv_mode) begin
      case (d_cnt)
        `TB_SEQ_DW'(1): s11_q <= doutb[0];
        `TB_SEQ_DW'(2): begin
          s12_q     <= doutb[0];
          s12_s21_q <= doutb[0] * doutb[1];
        end
        `TB_SEQ_DW'(3): begin
          s22_q     <= doutb[1];
          s11_s22_q <= s11_q * doutb[1];
        end
        `TB_SEQ_DW'(4): det_q <= s11_s22_q - s12_s21_q;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      b_row       <= '0;
      b_cache_row <= '0;
    end else begin
      b_row       <= b_next;
      b_cache_row <= cache_next;
    end
  end

  a_det_nonzero: assert property (
    @(posedge clk) disable iff (sys_rst)
    (inv_mode && d_cnt inside {`TB_SEQ_DW'(5), `TB_SEQ_DW'(6), `TB_SEQ_DW'(7)})
      |-> det_q != '0
  ) else $error("tb_doutb_map zero determinant in inverse");

endmodule

// ==== verilog/tb_subsys_top.sv ====
`timescale 1ns/10ps
`include "tb_params.svh"

module tb_subsys_top
  import tb_map_pkg::*;
(
  input  logic              clk,
  input  logic              sys_rst,
  input  logic              wr_en,
  input  logic [`TB_AW-1:0] wr_addr,
  input  tb_row_t           wr_row,
  input  logic              cmd_start,
  input  tb_cmd_t           cmd,
  output logic              busy,
  output tb_row_t           b_row,
  output tb_row_t           b_cache_row
);

  logic [`TB_AW-1:0]     rd_addr;
  logic [`TB_SEQ_DW-1:0] seq_cnt;
  tb_sel_t               sel;
  logic                  l_k_0;
  tb_row_t               bank_row;

  tb_bank u_bank (
    .clk     (clk),
    .sys_rst (sys_rst),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_row  (wr_row),
    .rd_addr (rd_addr),
    .rd_row  (bank_row)
  );

  tb_read_seq u_seq (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .cmd_start (cmd_start),
    .cmd       (cmd),
    .busy      (busy),
    .rd_addr   (rd_addr),
    .seq_cnt   (seq_cnt),
    .sel       (sel),
    .l_k_0     (l_k_0)
  );

  tb_doutb_map u_map (
    .clk         (clk),
    .sys_rst     (sys_rst),
    .sel         (sel),
    .l_k_0       (l_k_0),
    .seq_cnt     (seq_cnt),
    .doutb       (bank_row),
    .b_row       (b_row),
    .b_cache_row (b_cache_row)
  );

endmodule

// ==== test/tb_subsys_tb.sv ====
`timescale 1ns/10ps
`include "tb_params.svh"

module tb_subsys_tb
  import tb_map_pkg::*;
();

  localparam int N_TESTS     = 5;
  localparam int TIMEOUT_CYC = N_TESTS * 40 + 200;
  localparam int BUSY_CYC    = `TB_BURST_LEN + `TB_DRAIN;
  localparam int FIRST_SLOT  = `TB_RD_LAT + 1;
  localparam int LAST_STEP   = BUSY_CYC + 1;

  logic              clk;
  logic              sys_rst;
  logic              wr_en;
  logic [`TB_AW-1:0] wr_addr;
  tb_row_t           wr_row;
  logic              cmd_start;
  tb_cmd_t           cmd;
  logic              busy;
  tb_row_t           b_row;
  tb_row_t           b_cache_row;

  tb_row_t model [2**`TB_AW];
  integer  seed;
  int      errors;
  int      rows_checked;
  int      tests_done;
  int      err0;

  // Expected responses are driven on the falling edge.
  logic    exp_busy;
  logic    exp_vld;
  tb_row_t exp_b;
  tb_row_t exp_c;
  logic    b_zero;
  logic    c_zero;

  tb_subsys_top DUT (
    .clk         (clk),
    .sys_rst     (sys_rst),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_row      (wr_row),
    .cmd_start   (cmd_start),
    .cmd         (cmd),
    .busy        (busy),
    .b_row       (b_row),
    .b_cache_row (b_cache_row)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  a_busy: assert property (@(posedge clk) disable iff (sys_rst) busy == exp_busy)
    else begin
      $display("MISMATCH at %0t: busy differs from expected %b", $time, exp_busy);
      errors++;
    end

  a_b_row: assert property (@(posedge clk) disable iff (sys_rst) exp_vld |-> b_row == exp_b)
    else begin
      $display("MISMATCH at %0t: b_row differs from expected %h", $time, exp_b);
      errors++;
    end

  a_c_row: assert property (
    @(posedge clk) disable iff (sys_rst) exp_vld |-> b_cache_row == exp_c
  ) else begin
    $display("MISMATCH at %0t: b_cache_row differs from expected %h", $time, exp_c);
    errors++;
  end

  a_b_zero: assert property (@(posedge clk) disable iff (sys_rst) b_zero |-> b_row == '0)
    else begin
      $display("MISMATCH at %0t: b_row should be zero", $time);
      errors++;
    end

  a_c_zero: assert property (
    @(posedge clk) disable iff (sys_rst) c_zero |-> b_cache_row == '0
  ) else begin
    $display("MISMATCH at %0t: b_cache_row should be zero", $time);
    errors++;
  end

  function automatic tb_cmd_t make_cmd(logic target, logic [1:0] mode, logic lk,
                                       logic [`TB_AW-1:0] base);
    tb_cmd_t c;
    c.sel.target = target;
    c.sel.mode   = mode;
    c.l_k_0      = lk;
    c.base       = base;
    return c;
  endfunction

  function automatic tb_row_t rand_row();
    tb_row_t r;
    for (int i = 0; i < `TB_LANES; i++) begin
      r[i] = $random(seed);
    end
    return r;
  endfunction

  function automatic tb_row_t ref_b(logic [1:0] mode, logic lk, tb_row_t r);
    tb_row_t o;
    o = '0;
    case (mode)
      DIR_POS: o = r;
      DIR_NEG: begin
        for (int i = 0; i < 4; i++) begin
          o[i] = r[3-i];
        end
      end
      DIR_NEW: begin
        o[0] = lk ? r[0] : r[2];
        o[1] = lk ? r[1] : r[3];
      end
      default: o = '0;
    endcase
    return o;
  endfunction

  function automatic tb_row_t ref_c(logic [1:0] mode, logic lk, int d, tb_row_t r,
                                    logic [`TB_DW-1:0] s11, logic [`TB_DW-1:0] s12,
                                    logic [`TB_DW-1:0] s22, logic [`TB_DW-1:0] det);
    tb_row_t           o;
    logic [`TB_DW-1:0] p0;
    logic [`TB_DW-1:0] p1;
    o  = '0;
    p0 = lk ? r[0] : r[2];
    p1 = lk ? r[1] : r[3];
    case (mode)
      CACHE_TRANSFER: begin
        o[0] = r[0];
        o[1] = r[1];
      end
      CACHE_TRANSPOSE: begin
        case (d)
          1: o[0] = r[0];
          2: begin
            o[0] = r[1];
            o[1] = r[0];
          end
          3: begin
            o[0] = r[2];
            o[1] = r[1];
          end
          4: o[1] = r[2];
          5: o[0] = p0;
          6: begin
            o[0] = p1;
            o[1] = p0;
          end
          7: o[1] = p1;
          default: o = '0;
        endcase
      end
      CACHE_INV: begin
        case (d)
          5: o[0] = s11 / det;
          6: begin
            o[0] = s12 / det;
            o[1] = s12 / det;
          end
          7: o[1] = s22 / det;
          default: o = '0;
        endcase
      end
      default: o = '0;
    endcase
    return o;
  endfunction

  // Leaves wr_en high until the next burst drops it.
  task automatic write_row(input logic [`TB_AW-1:0] addr, input tb_row_t row);
    @(negedge clk);
    wr_en   = 1'b1;
    wr_addr = addr;
    wr_row  = row;
    model[addr] = row;
  endtask

  // Symmetric 2x2 block with a small determinant of at least 1.
  task automatic write_inv_rows(input logic [`TB_AW-1:0] base);
    tb_row_t           r1;
    tb_row_t           r2;
    tb_row_t           r3;
    logic [`TB_DW-1:0] s11;
    logic [`TB_DW-1:0] s12;
    logic [`TB_DW-1:0] s22;
    s11 = 32'd1 + ($unsigned($random(seed)) % 32'd4);
    s12 = $unsigned($random(seed)) % 32'd300;
    s22 = (s12 * s12) / s11 + 32'd1 + ($unsigned($random(seed)) % 32'd3);
    r1 = rand_row();
    r1[0] = s11;
    r2 = rand_row();
    r2[0] = s12;
    r2[1] = s12;
    r3 = rand_row();
    r3[1] = s22;
    write_row(base + `TB_AW'(1), r1);
    write_row(base + `TB_AW'(2), r2);
    write_row(base + `TB_AW'(3), r3);
  endtask

  task automatic run_burst(input logic target, input logic [1:0] mode, input logic lk,
                           input logic [`TB_AW-1:0] base, input bit stray);
    tb_row_t           eb [`TB_BURST_LEN];
    tb_row_t           ec [`TB_BURST_LEN];
    logic [`TB_DW-1:0] s11;
    logic [`TB_DW-1:0] s12;
    logic [`TB_DW-1:0] s21;
    logic [`TB_DW-1:0] s22;
    logic [`TB_DW-1:0] det;
    logic [`TB_AW-1:0] a;
    logic              active;
    a   = base + `TB_AW'(1);
    s11 = model[a][0];
    a   = base + `TB_AW'(2);
    s12 = model[a][0];
    s21 = model[a][1];
    a   = base + `TB_AW'(3);
    s22 = model[a][1];
    det = s11 * s22 - s12 * s21;
    for (int k = 0; k < `TB_BURST_LEN; k++) begin
      a = base + `TB_AW'(k);
      eb[k] = (target == TGT_B) ? ref_b(mode, lk, model[a]) : '0;
      ec[k] = (target == TGT_CACHE) ? ref_c(mode, lk, k, model[a], s11, s12, s22, det) : '0;
    end
    @(negedge clk);
    wr_en     = 1'b0;
    cmd_start = 1'b1;
    cmd       = make_cmd(target, mode, lk, base);
    // Step n is the cycle after the n-th edge since the command was latched.
    for (int n = 0; n <= LAST_STEP; n++) begin
      @(negedge clk);
      cmd_start = stray && (n == 3);
      if (stray && n == 3) begin
        cmd = make_cmd(!target, 2'd2, !lk, ~base);
      end
      active   = (n >= 1) && (n < LAST_STEP);
      b_zero   = !(active && target == TGT_B && mode != DIR_IDLE);
      c_zero   = !(active && target == TGT_CACHE && mode != CACHE_IDLE);
      exp_busy = (n < BUSY_CYC);
      exp_vld  = (n >= FIRST_SLOT) && (n < FIRST_SLOT + `TB_BURST_LEN);
      if (exp_vld) begin
        exp_b = eb[n - FIRST_SLOT];
        exp_c = ec[n - FIRST_SLOT];
        rows_checked++;
      end
    end
    // The last step is compared on the rising edge before this one.
    @(negedge clk);
  endtask

  task automatic report_test(input string name);
    tests_done++;
    $display("test %0d %s: %s, %0d errors", tests_done, name,
             (errors == err0) ? "passed" : "failed", errors - err0);
    err0 = errors;
  endtask

  initial begin
    repeat (TIMEOUT_CYC) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run appears to hang", TIMEOUT_CYC);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    seed         = 82;
    errors       = 0;
    rows_checked = 0;
    tests_done   = 0;
    err0         = 0;
    sys_rst      = 1'b1;
    wr_en        = 1'b0;
    wr_addr      = '0;
    wr_row       = '0;
    cmd_start    = 1'b0;
    cmd          = '0;
    exp_busy     = 1'b0;
    exp_vld      = 1'b0;
    exp_b        = '0;
    exp_c        = '0;
    b_zero       = 1'b1;
    c_zero       = 1'b1;
    repeat (16) @(negedge clk);
    sys_rst = 1'b0;

    repeat (3) @(negedge clk);
    for (int i = 0; i < 32; i++) begin
      write_row(`TB_AW'(i), rand_row());
    end
    run_burst(TGT_B, DIR_POS, 1'b1, 6'd0, 1'b1);
    report_test("reset, busy length and ignored start");

    run_burst(TGT_B, DIR_POS, 1'b1, 6'd4, 1'b0);
    run_burst(TGT_B, DIR_NEG, 1'b0, 6'd8, 1'b0);
    run_burst(TGT_B, DIR_NEW, 1'b1, 6'd12, 1'b0);
    run_burst(TGT_B, DIR_NEW, 1'b0, 6'd16, 1'b0);
    report_test("B operand modes");

    run_burst(TGT_CACHE, CACHE_TRANSFER, 1'b1, 6'd2, 1'b0);
    run_burst(TGT_CACHE, CACHE_TRANSFER, 1'b0, 6'd10, 1'b0);
    run_burst(TGT_CACHE, CACHE_TRANSPOSE, 1'b1, 6'd5, 1'b0);
    run_burst(TGT_CACHE, CACHE_TRANSPOSE, 1'b0, 6'd20, 1'b0);
    report_test("B cache transfer and transpose");

    write_inv_rows(6'd24);
    run_burst(TGT_CACHE, CACHE_INV, 1'b1, 6'd24, 1'b0);
    write_inv_rows(6'd0);
    run_burst(TGT_CACHE, CACHE_INV, 1'b0, 6'd0, 1'b0);
    write_inv_rows(6'd13);
    run_burst(TGT_CACHE, CACHE_INV, 1'b1, 6'd13, 1'b0);
    report_test("B cache inverse");

    for (int i = 8; i < 16; i++) begin
      write_row(`TB_AW'(i), rand_row());
    end
    run_burst(TGT_B, DIR_POS, 1'b1, 6'd8, 1'b0);
    run_burst(TGT_B, DIR_IDLE, 1'b1, 6'd3, 1'b0);
    run_burst(TGT_CACHE, CACHE_IDLE, 1'b0, 6'd7, 1'b0);
    report_test("rewrite and idle commands");

    $display("tests %0d, rows checked %0d, errors %0d", tests_done, rows_checked, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+verilog
verilog/tb_map_pkg.sv
verilog/dynamic_shreg.sv
verilog/tb_bank.sv
verilog/tb_read_seq.sv
verilog/tb_doutb_map.sv
verilog/tb_subsys_top.sv
test/tb_subsys_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the TB read-side testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f files.f --top-module tb_subsys_tb -o sim_tb
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

sim_out=$(./obj_dir/sim_tb)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "TEST OK"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
